/* verilog/ddr_consts.svh */
`ifndef DDR_CONSTS_SVH
`define DDR_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// pixel and beat geometry
////////////////////////////////////////////////////////////////////////////
`define PIX_W        24          // rgb888 pixel
`define SLOT_W       32          // one pixel slot inside a beat, top byte zero
`define BEAT_PIX     8           // pixels packed per ddr beat
`define BEAT_W       256         // ddr beat width

////////////////////////////////////////////////////////////////////////////
// ddr burst and buffering
////////////////////////////////////////////////////////////////////////////
`define BURST_BEATS  4           // beats per burst, also the wr_len value
`define LEN_W        16          // width of the burst length port
`define FIFO_DEPTH   16          // beats held per channel

////////////////////////////////////////////////////////////////////////////
// address map
////////////////////////////////////////////////////////////////////////////
`define ADDR_W       27
`define FRAME_STRIDE 4096        // offset of bank 1 from bank 0
`define CH0_BASE     0
`define CH1_BASE     16384

`endif

/* verilog/video_pkg.sv */
`default_nettype none

`include "ddr_consts.svh"

////////////////////////////////////////////////////////////////////////////
// video side data types
////////////////////////////////////////////////////////////////////////////
package video_pkg;

  // one incoming pixel as it arrives from a channel
  typedef logic [`PIX_W-1:0] pixel_t;

  // packed ddr beat, pixel 0 in the lowest slot
  typedef logic [`BEAT_W-1:0] beat_t;

endpackage

`default_nettype wire

/* verilog/ddr_pkg.sv */
`default_nettype none

`include "ddr_consts.svh"

////////////////////////////////////////////////////////////////////////////
// ddr side types
////////////////////////////////////////////////////////////////////////////
package ddr_pkg;

  typedef logic [`ADDR_W-1:0] ddr_addr_t;  // beat address on the ddr port

  // burst arbiter FSM
  typedef enum logic [1:0] {
    SCAN,       // look at one channel per cycle
    REQ,        // wreq raised, waiting for first data request
    DATA,       // beats moving
    WAIT_DONE   // all beats sent, waiting for wdone
  } arb_state_t;

endpackage

`default_nettype wire

/* verilog/wr_chan_if.sv */
`timescale 1ns/1ps
`default_nettype none

// link between one channel writer and the burst arbiter
interface wr_chan_if;

  logic                burst_rdy;   // level, fifo holds a whole burst
  ddr_pkg::ddr_addr_t  burst_addr;  // address of the next burst
  video_pkg::beat_t    head_beat;   // show-ahead head of the fifo
  logic                pop;         // strobe, drop head beat
  logic                burst_done;  // strobe, burst written

  modport chan (
    output burst_rdy,
    output burst_addr,
    output head_beat,
    input  pop,
    input  burst_done
  );

  modport arb (
    input  burst_rdy,
    input  burst_addr,
    input  head_beat,
    output pop,
    output burst_done
  );

endinterface

`default_nettype wire

/* verilog/beat_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_consts.svh"

module beat_fifo (
  input  wire              ddr_clk,
  input  wire              ddr_rstn,
  input  wire              i_push,
  input  video_pkg::beat_t i_data,
  input  wire              i_pop,
  output video_pkg::beat_t o_head,
  output logic [4:0]       o_level,
  output logic             o_full
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);

  video_pkg::beat_t mem [`FIFO_DEPTH];  // beat storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && (o_level != '0);

  assign o_head = mem[rd_ptr];                    // show-ahead read
  assign o_full = (o_level == 5'(`FIFO_DEPTH));

  always_ff @(posedge ddr_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge ddr_clk) begin
    if (ddr_rstn) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      o_level <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;                  // wraps at depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   o_level <= o_level + 1'b1;
        2'b01:   o_level <= o_level - 1'b1;
        default: o_level <= o_level;              // both or neither
      endcase
    end
  end

  // the arbiter only pops inside a granted burst, so the level must cover it
  a_no_pop_empty: assert property (
    @(posedge ddr_clk) disable iff (ddr_rstn)
    i_pop |-> (o_level != '0)
  );

endmodule

`default_nettype wire

/* verilog/chan_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_consts.svh"

module chan_writer #(
  parameter int unsigned BASE = `CH0_BASE
) (
  input  wire                ddr_clk,
  input  wire                ddr_rstn,
  input  wire                i_pix_valid,
  input  video_pkg::pixel_t  i_pix,
  input  wire                i_fsync,
  wr_chan_if.chan            wr,
  output logic               o_bank
);

  localparam int CNT_W = $clog2(`BEAT_PIX);

  ////////////////////////////////////////////////////////////////////////////
  // pixel packing
  ////////////////////////////////////////////////////////////////////////////
  logic [CNT_W-1:0]   pix_cnt;      // slot for the next pixel
  video_pkg::beat_t   pack_q;       // beat under assembly
  logic               push_q;       // full beat ready for the fifo
  logic [4:0]         fifo_level;
  logic               fifo_full;
  ddr_pkg::ddr_addr_t burst_ptr;    // offset of next burst within the frame
  ddr_pkg::ddr_addr_t bank_off;

  always_ff @(posedge ddr_clk) begin
    if (i_pix_valid && !i_fsync) begin
      pack_q[pix_cnt*`SLOT_W +: `SLOT_W] <= `SLOT_W'(i_pix);  // top byte zero
    end
  end

  always_ff @(posedge ddr_clk) begin
    if (ddr_rstn) begin
      pix_cnt <= '0;
      push_q  <= 1'b0;
    end else begin
      push_q <= 1'b0;
      if (i_fsync) begin
        pix_cnt <= '0;                            // drop a partial beat
      end else if (i_pix_valid) begin
        if (pix_cnt == CNT_W'(`BEAT_PIX - 1)) begin
          pix_cnt <= '0;
          push_q  <= 1'b1;                        // push lands next cycle
        end else begin
          pix_cnt <= pix_cnt + 1'b1;
        end
      end
    end
  end

  beat_fifo u_beat_fifo (
    .ddr_clk  (ddr_clk),
    .ddr_rstn (ddr_rstn),
    .i_push   (push_q),
    .i_data   (pack_q),
    .i_pop    (wr.pop),
    .o_head   (wr.head_beat),
    .o_level  (fifo_level),
    .o_full   (fifo_full)
  );

  ////////////////////////////////////////////////////////////////////////////
  // burst pointer and frame bank
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge ddr_clk) begin
    if (ddr_rstn) begin
      burst_ptr <= '0;
      o_bank    <= 1'b0;
    end else if (i_fsync) begin
      burst_ptr <= '0;
      o_bank    <= ~o_bank;                       // ping-pong per frame
    end else if (wr.burst_done) begin
      burst_ptr <= burst_ptr + ddr_pkg::ddr_addr_t'(`BURST_BEATS);
    end
  end

  assign bank_off = o_bank ? ddr_pkg::ddr_addr_t'(`FRAME_STRIDE) : '0;

  assign wr.burst_addr = ddr_pkg::ddr_addr_t'(BASE) + bank_off + burst_ptr;
  assign wr.burst_rdy  = (fifo_level >= 5'(`BURST_BEATS));  // water level

  // arbiter must drain faster than pixels arrive
  a_no_push_full: assert property (
    @(posedge ddr_clk) disable iff (ddr_rstn)
    push_q |-> !fifo_full
  );

endmodule

`default_nettype wire

/* verilog/burst_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_consts.svh"

module burst_arbiter (
  input  wire                       ddr_clk,
  input  wire                       ddr_rstn,
  wr_chan_if.arb                    ch0,
  wr_chan_if.arb                    ch1,
  output logic                      o_ddr_wreq,
  output ddr_pkg::ddr_addr_t        o_ddr_waddr,
  output logic [`LEN_W-1:0]         o_ddr_wr_len,
  output video_pkg::beat_t          o_ddr_wdata,
  input  wire                       i_ddr_wdata_req,
  input  wire                       i_ddr_wdone
);

  localparam int BCNT_W = $clog2(`BURST_BEATS);

  ddr_pkg::arb_state_t state;
  logic                sel;         // round-robin pointer, 1 selects ch1
  logic [BCNT_W-1:0]   beat_cnt;    // beats already handed over
  logic                sel_rdy;
  logic                xfer;        // beat leaves this cycle
  logic                fin;         // burst closed by ddr side

  assign sel_rdy = sel ? ch1.burst_rdy : ch0.burst_rdy;
  assign xfer    = i_ddr_wdata_req &&
                   (state == ddr_pkg::REQ || state == ddr_pkg::DATA);
  assign fin     = i_ddr_wdone &&
                   (state == ddr_pkg::DATA || state == ddr_pkg::WAIT_DONE);

  ////////////////////////////////////////////////////////////////////////////
  // grant FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge ddr_clk) begin
    if (ddr_rstn) begin
      state      <= ddr_pkg::SCAN;
      sel        <= 1'b0;
      beat_cnt   <= '0;
      o_ddr_wreq <= 1'b0;
    end else begin
      case (state)
        ddr_pkg::SCAN: begin
          if (sel_rdy) begin
            state      <= ddr_pkg::REQ;           // grant current channel
            o_ddr_wreq <= 1'b1;
            beat_cnt   <= '0;
          end else begin
            sel <= ~sel;                          // try the other one
          end
        end
        ddr_pkg::REQ: begin
          if (xfer) begin
            o_ddr_wreq <= 1'b0;                   // first beat accepted
            beat_cnt   <= beat_cnt + 1'b1;
            state      <= ddr_pkg::DATA;
          end
        end
        ddr_pkg::DATA: begin
          if (fin) begin
            state <= ddr_pkg::SCAN;
            sel   <= ~sel;
          end else if (xfer) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == BCNT_W'(`BURST_BEATS - 1)) begin
              state <= ddr_pkg::WAIT_DONE;
            end
          end
        end
        ddr_pkg::WAIT_DONE: begin
          if (fin) begin
            state <= ddr_pkg::SCAN;
            sel   <= ~sel;                        // next scan starts elsewhere
          end
        end
        default: state <= ddr_pkg::SCAN;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // ddr port mux and strobe routing
  ////////////////////////////////////////////////////////////////////////////
  assign o_ddr_waddr  = sel ? ch1.burst_addr : ch0.burst_addr;
  assign o_ddr_wdata  = sel ? ch1.head_beat : ch0.head_beat;
  assign o_ddr_wr_len = `LEN_W'(`BURST_BEATS);

  assign ch0.pop        = xfer && !sel;
  assign ch1.pop        = xfer && sel;
  assign ch0.burst_done = fin && !sel;
  assign ch1.burst_done = fin && sel;

  // request register must fall before the FSM goes back to scanning
  a_no_wreq_scan: assert property (
    @(posedge ddr_clk) disable iff (ddr_rstn)
    (state == ddr_pkg::SCAN) |-> !o_ddr_wreq
  );

  // ddr side only asks for data inside a granted burst
  a_no_dreq_scan: assert property (
    @(posedge ddr_clk) disable iff (ddr_rstn)
    (state == ddr_pkg::SCAN) |-> !i_ddr_wdata_req
  );

endmodule

`default_nettype wire

/* verilog/wr_frame_buf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_consts.svh"

module wr_frame_buf (
  input  wire                 ddr_clk,
  input  wire                 ddr_rstn,
  // channel 0 video
  input  wire                 i_ch0_pix_valid,
  input  video_pkg::pixel_t   i_ch0_pix,
  input  wire                 i_ch0_fsync,
  // channel 1 video
  input  wire                 i_ch1_pix_valid,
  input  video_pkg::pixel_t   i_ch1_pix,
  input  wire                 i_ch1_fsync,
  // ddr write port
  output logic                o_ddr_wreq,
  output ddr_pkg::ddr_addr_t  o_ddr_waddr,
  output logic [`LEN_W-1:0]   o_ddr_wr_len,
  output video_pkg::beat_t    o_ddr_wdata,
  input  wire                 i_ddr_wdata_req,
  input  wire                 i_ddr_wdone,
  output logic [1:0]          o_frame_flags
);

  wr_chan_if ch0_if ();
  wr_chan_if ch1_if ();

  logic ch0_bank;
  logic ch1_bank;

  chan_writer #(.BASE(`CH0_BASE)) u_chan0 (
    .ddr_clk     (ddr_clk),
    .ddr_rstn    (ddr_rstn),
    .i_pix_valid (i_ch0_pix_valid),
    .i_pix       (i_ch0_pix),
    .i_fsync     (i_ch0_fsync),
    .wr          (ch0_if),
    .o_bank      (ch0_bank)
  );

  chan_writer #(.BASE(`CH1_BASE)) u_chan1 (
    .ddr_clk     (ddr_clk),
    .ddr_rstn    (ddr_rstn),
    .i_pix_valid (i_ch1_pix_valid),
    .i_pix       (i_ch1_pix),
    .i_fsync     (i_ch1_fsync),
    .wr          (ch1_if),
    .o_bank      (ch1_bank)
  );

  burst_arbiter u_arbiter (
    .ddr_clk         (ddr_clk),
    .ddr_rstn        (ddr_rstn),
    .ch0             (ch0_if),
    .ch1             (ch1_if),
    .o_ddr_wreq      (o_ddr_wreq),
    .o_ddr_waddr     (o_ddr_waddr),
    .o_ddr_wr_len    (o_ddr_wr_len),
    .o_ddr_wdata     (o_ddr_wdata),
    .i_ddr_wdata_req (i_ddr_wdata_req),
    .i_ddr_wdone     (i_ddr_wdone)
  );

  assign o_frame_flags = {ch0_bank, ch1_bank};  // ch0 in the upper bit

endmodule

`default_nettype wire

/* sim/ddr_responder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_consts.svh"

// ddr write slave model, takes one burst at a time and reports it when done
module ddr_responder (
  input  wire                             ddr_clk,
  input  wire                             ddr_rstn,
  input  wire                             i_hold,       // leave requests waiting
  input  wire                             i_stall,      // idle this cycle
  input  wire                             i_wreq,
  input  ddr_pkg::ddr_addr_t              i_waddr,
  input  wire [`LEN_W-1:0]                i_wr_len,
  input  video_pkg::beat_t                i_wdata,
  output logic                            o_wdata_req,
  output logic                            o_wdone,
  output logic                            o_rec_valid,  // one cycle per finished burst
  output ddr_pkg::ddr_addr_t              o_rec_addr,
  output logic [`LEN_W-1:0]               o_rec_len,
  output logic [`BURST_BEATS*`BEAT_W-1:0] o_rec_beats
);

  logic [1:0] phase;    // 0 idle, 1 beats, 2 done
  int         nbeat;
  logic       hold_s;
  logic       stall_s;
  logic       rst_s;

  initial begin
    o_wdata_req = 1'b0;
    o_wdone     = 1'b0;
    o_rec_valid = 1'b0;
    o_rec_addr  = '0;
    o_rec_len   = '0;
    o_rec_beats = '0;
    phase       = 2'd0;
    nbeat       = 0;
    forever begin
      @(posedge ddr_clk);
      hold_s  = i_hold;                           // testbench controls, taken at the edge
      stall_s = i_stall;
      rst_s   = ddr_rstn;
      #1;
      o_wdata_req = 1'b0;
      o_wdone     = 1'b0;
      o_rec_valid = 1'b0;
      if (rst_s) begin
        phase = 2'd0;
      end else begin
        case (phase)
          2'd0: begin
            if (i_wreq && !hold_s) begin
              o_rec_addr = i_waddr;               // held by the dut until wdone
              o_rec_len  = i_wr_len;
              nbeat      = 0;
              phase      = 2'd1;
            end
          end
          2'd1: begin
            if (!stall_s) begin
              o_wdata_req = 1'b1;
              o_rec_beats[nbeat*`BEAT_W +: `BEAT_W] = i_wdata;  // beat popped at next edge
              nbeat = nbeat + 1;
              if (nbeat == `BURST_BEATS) begin
                phase = 2'd2;
              end
            end
          end
          default: begin
            if (!stall_s) begin
              o_wdone     = 1'b1;
              o_rec_valid = 1'b1;
              phase       = 2'd0;
            end
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_wr_frame_buf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_consts.svh"

module tb_wr_frame_buf;

  logic                            ddr_clk;
  logic                            ddr_rstn;
  logic                            ch0_valid, ch1_valid;
  video_pkg::pixel_t               ch0_pix, ch1_pix;
  logic                            ch0_fsync, ch1_fsync;
  logic                            wreq, wdata_req, wdone;
  ddr_pkg::ddr_addr_t              waddr, rec_addr;
  logic [`LEN_W-1:0]               wr_len, rec_len;
  video_pkg::beat_t                wdata;
  logic [1:0]                      frame_flags;
  logic                            hold, stall, rec_valid;
  logic [`BURST_BEATS*`BEAT_W-1:0] rec_beats;

  logic [31:0]      lfsr;
  video_pkg::beat_t exp_q0[$];      // expected beats of channel 0
  video_pkg::beat_t exp_q1[$];
  video_pkg::beat_t pack_beat [2];  // model beat under assembly
  int               pack_cnt [2];
  int               exp_ptr [2];
  logic             exp_bank [2];
  logic             alt_on;         // grant order under test
  int               alt_prev;
  int               alt_count;

  wr_frame_buf i_wr_frame_buf (
    .ddr_clk (ddr_clk), .ddr_rstn (ddr_rstn),
    .i_ch0_pix_valid (ch0_valid), .i_ch0_pix (ch0_pix), .i_ch0_fsync (ch0_fsync),
    .i_ch1_pix_valid (ch1_valid), .i_ch1_pix (ch1_pix), .i_ch1_fsync (ch1_fsync),
    .o_ddr_wreq (wreq), .o_ddr_waddr (waddr), .o_ddr_wr_len (wr_len),
    .o_ddr_wdata (wdata), .i_ddr_wdata_req (wdata_req), .i_ddr_wdone (wdone),
    .o_frame_flags (frame_flags)
  );

  ddr_responder u_ddr (
    .ddr_clk (ddr_clk), .ddr_rstn (ddr_rstn), .i_hold (hold), .i_stall (stall),
    .i_wreq (wreq), .i_waddr (waddr), .i_wr_len (wr_len), .i_wdata (wdata),
    .o_wdata_req (wdata_req), .o_wdone (wdone), .o_rec_valid (rec_valid),
    .o_rec_addr (rec_addr), .o_rec_len (rec_len), .o_rec_beats (rec_beats)
  );

  always #4 ddr_clk = ~ddr_clk;

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_val(input string name, input logic [`BEAT_W-1:0] got,
                           input logic [`BEAT_W-1:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      stop_run();
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // right-shift galois form
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // every input change lands 1 ns after the edge
  task automatic next_cycle();
    logic [31:0] r;
    @(posedge ddr_clk);
    #1;
    rand_bits(1, r);
    stall = r[0];                                 // responder delay
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and packing model
  ////////////////////////////////////////////////////////////////////////////
  task automatic drive_chan(input int ch, inout int left);
    logic [31:0] r;
    logic        v;
    rand_bits(1, r);
    v = r[0] && (left > 0);                       // random valid gaps
    rand_bits(`PIX_W, r);
    if (ch == 0) begin
      ch0_valid = v;
      ch0_pix   = r[`PIX_W-1:0];
    end else begin
      ch1_valid = v;
      ch1_pix   = r[`PIX_W-1:0];
    end
    if (v) begin
      left = left - 1;
      pack_beat[ch][pack_cnt[ch]*`SLOT_W +: `SLOT_W] =
        {{(`SLOT_W-`PIX_W){1'b0}}, r[`PIX_W-1:0]};  // first pixel lowest
      pack_cnt[ch] = pack_cnt[ch] + 1;
      if (pack_cnt[ch] == `BEAT_PIX) begin
        pack_cnt[ch] = 0;
        if (ch == 0) exp_q0.push_back(pack_beat[0]);
        else exp_q1.push_back(pack_beat[1]);
      end
    end
  endtask

  task automatic send_pixels(input int n0, input int n1);
    int guard;
    guard = 0;
    while (n0 > 0 || n1 > 0) begin
      next_cycle();
      drive_chan(0, n0);
      drive_chan(1, n1);
      guard = guard + 1;
      if (guard > 4000) begin
        $display("timeout while sending pixels");
        stop_run();
      end
    end
    next_cycle();
    ch0_valid = 1'b0;
    ch1_valid = 1'b0;
  endtask

  task automatic wait_drain(input string what);
    int guard;
    guard = 0;
    while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      next_cycle();
      guard = guard + 1;
      if (guard > 4000) begin
        $display("timeout waiting for %s to reach ddr", what);
        stop_run();
      end
    end
  endtask

  task automatic pulse_fsync(input int ch);
    next_cycle();
    if (ch == 0) begin
      ch0_fsync = 1'b1;
    end else begin
      ch1_fsync = 1'b1;
    end
    next_cycle();
    ch0_fsync    = 1'b0;
    ch1_fsync    = 1'b0;
    exp_bank[ch] = ~exp_bank[ch];                 // new frame uses the other bank
    exp_ptr[ch]  = 0;
    check_val("o_frame_flags", frame_flags, {exp_bank[0], exp_bank[1]});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // burst checker
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_burst();
    int                 ch;
    int                 i;
    ddr_pkg::ddr_addr_t exp_addr;
    video_pkg::beat_t   exp_beat;
    ch       = (rec_addr >= `CH1_BASE) ? 1 : 0;   // channel from address range
    exp_addr = ddr_pkg::ddr_addr_t'((ch ? `CH1_BASE : `CH0_BASE) +
               (exp_bank[ch] ? `FRAME_STRIDE : 0) + exp_ptr[ch]);
    check_val("o_ddr_waddr", rec_addr, exp_addr);
    check_val("o_ddr_wr_len", rec_len, `BURST_BEATS);
    for (i = 0; i < `BURST_BEATS; i++) begin
      if ((ch == 0 && exp_q0.size() == 0) || (ch == 1 && exp_q1.size() == 0)) begin
        $display("burst on channel %0d carries beats that were never sent", ch);
        stop_run();
      end
      if (ch == 0) exp_beat = exp_q0.pop_front();
      else exp_beat = exp_q1.pop_front();
      check_val("o_ddr_wdata", rec_beats[i*`BEAT_W +: `BEAT_W], exp_beat);
    end
    exp_ptr[ch] = exp_ptr[ch] + `BURST_BEATS;
    if (alt_on) begin
      if (alt_prev >= 0) check_val("burst channel", ch, 1 - alt_prev);
      alt_prev  = ch;
      alt_count = alt_count + 1;
    end
  endtask

  always @(posedge ddr_clk) begin
    if (rec_valid) check_burst();
  end

  initial begin
    int          f;
    int          n0;
    logic [31:0] r;
    ddr_clk   = 1'b0;
    ddr_rstn  = 1'b1;
    ch0_valid = 1'b0;
    ch1_valid = 1'b0;
    ch0_pix   = '0;
    ch1_pix   = '0;
    ch0_fsync = 1'b0;
    ch1_fsync = 1'b0;
    hold      = 1'b0;
    stall     = 1'b0;
    lfsr      = 32'd92997;
    pack_cnt  = '{0, 0};
    exp_ptr   = '{0, 0};
    exp_bank  = '{1'b0, 1'b0};
    alt_on    = 1'b0;
    alt_prev  = -1;
    alt_count = 0;
    for (f = 0; f < 8; f++) next_cycle();
    ddr_rstn = 1'b0;
    next_cycle();
    check_val("o_ddr_wreq", wreq, 0);
    check_val("o_frame_flags", frame_flags, 0);
    for (f = 0; f < 4; f++) begin
      rand_bits(2, r);
      n0 = (r + 1) * 32;
      rand_bits(2, r);
      send_pixels(n0, (r + 1) * 32);
      wait_drain("frame bursts");
      pulse_fsync(0);
      pulse_fsync(1);
    end
    hold = 1'b1;                                  // let both channels fill
    send_pixels(64, 64);
    next_cycle();
    next_cycle();
    alt_on = 1'b1;
    hold   = 1'b0;
    wait_drain("held bursts");
    check_val("alternating bursts", alt_count, 4);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+verilog
verilog/video_pkg.sv
verilog/ddr_pkg.sv
verilog/wr_chan_if.sv
verilog/beat_fifo.sv
verilog/chan_writer.sv
verilog/burst_arbiter.sv
verilog/wr_frame_buf.sv
sim/ddr_responder.sv
sim/tb_wr_frame_buf.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_wr_frame_buf -f build.f -Mdir obj_dir
./obj_dir/Vtb_wr_frame_buf > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
grep -q "TEST PASSED" sim.log
